// File: build.f
+incdir+include
logic/axi2apb_pkg.sv
logic/axi_chan_fifo.sv
logic/apb_xfer_fsm.sv
logic/axi2apb_bridge.sv
sim/apb_mem_model.sv
sim/tb_axi2apb.sv

// File: Makefile
# Verilator flow for the AXI4-to-APB bridge

VERILATOR ?= verilator
TOP       ?= tb_axi2apb
RTL_TOP   ?= axi2apb_bridge
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_axi2apb.sv
/* Bridge testbench: stimulus table, AXI master driving, response checks,
   watchdog */

`timescale 1ns/1ps

`include "axi2apb_defs.svh"

module tb_axi2apb;

  import axi2apb_pkg::*;

  localparam int CLK_T = 40;
  localparam int SEED  = 16819;

  // Queued ops go out without waiting for earlier responses
  typedef enum logic [2:0] {OP_WR, OP_RD, OP_RW, OP_WR_Q, OP_RD_Q} op_e;

  typedef struct packed {
    op_e                        op;
    logic [`AXI2APB_ID_W-1:0]   id;
    logic [`AXI2APB_ADDR_W-1:0] addr;
    logic [`AXI2APB_DATA_W-1:0] wdata;
    int                         hold;   // Ready low cycles before the response is taken
  } entry_t;

  typedef struct packed {
    int                         idx;
    logic [`AXI2APB_ID_W-1:0]   id;
    logic [`AXI2APB_DATA_W-1:0] data;
    axi_resp_e                  resp;
    int                         hold;
  } expect_t;

  logic                       ACLK;
  logic                       ARESETn;
  logic [`AXI2APB_ID_W-1:0]   awid_i;
  logic [`AXI2APB_ID_W-1:0]   arid_i;
  logic [`AXI2APB_ID_W-1:0]   bid_o;
  logic [`AXI2APB_ID_W-1:0]   rid_o;
  logic [`AXI2APB_ADDR_W-1:0] awaddr_i;
  logic [`AXI2APB_ADDR_W-1:0] araddr_i;
  logic [`AXI2APB_ADDR_W-1:0] paddr_o;
  logic [`AXI2APB_DATA_W-1:0] wdata_i;
  logic [`AXI2APB_DATA_W-1:0] rdata_o;
  logic [`AXI2APB_DATA_W-1:0] pwdata_o;
  logic [`AXI2APB_DATA_W-1:0] prdata_i;
  logic                       awvalid_i;
  logic                       awready_o;
  logic                       wvalid_i;
  logic                       wready_o;
  logic                       bvalid_o;
  logic                       bready_i;
  logic                       arvalid_i;
  logic                       arready_o;
  logic                       rvalid_o;
  logic                       rready_i;
  logic                       penable_o;
  logic                       pwrite_o;
  logic                       pready_i;
  logic                       pslverr_i;
  axi_resp_e                  bresp_o;
  axi_resp_e                  rresp_o;

  entry_t                     tab[$];
  expect_t                    exp_r[$];
  expect_t                    exp_b[$];
  int                         pend[$];   // Responses still owed per test
  logic                       bad[$];
  logic [`AXI2APB_DATA_W-1:0] ref_mem [16];
  int                         n_checks;
  int                         n_errs;
  int                         n_done;
  int                         n_failed;

  axi2apb_bridge dut0 (.*);

  apb_mem_model apb0 (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .penable_i(penable_o), .pwrite_i(pwrite_o), .paddr_i(paddr_o), .pwdata_i(pwdata_o),
    .prdata_o(prdata_i), .pready_o(pready_i), .pslverr_o(pslverr_i)
  );

  initial
  begin
    ACLK = 1'b0;
    forever
      #(CLK_T / 2) ACLK = ~ACLK;
  end

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_data(input string name, input logic [`AXI2APB_DATA_W-1:0] exp,
                            input logic [`AXI2APB_DATA_W-1:0] act);
    n_checks++;
    if (act !== exp)
    begin
      n_errs++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input logic [`AXI2APB_ADDR_W-1:0] exp,
                            input logic [`AXI2APB_ADDR_W-1:0] act);
    n_checks++;
    if (act !== exp)
    begin
      n_errs++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_id(input string name, input logic [`AXI2APB_ID_W-1:0] exp,
                          input logic [`AXI2APB_ID_W-1:0] act);
    n_checks++;
    if (act !== exp)
    begin
      n_errs++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
    n_checks++;
    if (act !== exp)
    begin
      n_errs++;
      $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp)
    begin
      n_errs++;
      $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // ------------------------------------------------------------
  // Table, prediction and AXI master
  // ------------------------------------------------------------
  task automatic add_entry(input op_e op, input logic [`AXI2APB_ID_W-1:0] id,
                           input logic [`AXI2APB_ADDR_W-1:0] addr,
                           input logic [`AXI2APB_DATA_W-1:0] wdata);
    entry_t e;
    e.op    = op;
    e.id    = id;
    e.addr  = addr;
    e.wdata = wdata;
    e.hold  = int'($urandom % 8);
    tab.push_back(e);
    pend.push_back(0);
    bad.push_back(1'b0);
  endtask

  // Read is predicted before the write, the bridge favours reads
  task automatic expect_entry(input int idx, input entry_t e);
    expect_t x;
    x.idx  = idx;
    x.id   = e.id;
    x.hold = e.hold;
    x.resp = e.addr[12] ? RESP_SLVERR : RESP_OKAY;
    x.data = '0;
    if (e.op != OP_WR && e.op != OP_WR_Q)
    begin
      if (!e.addr[12])
        x.data = ref_mem[e.addr[5:2]];
      exp_r.push_back(x);
      pend[idx]++;
    end
    if (e.op != OP_RD && e.op != OP_RD_Q)
    begin
      x.data = '0;
      if (!e.addr[12])
        ref_mem[e.addr[5:2]] = e.wdata;
      exp_b.push_back(x);
      pend[idx]++;
    end
  endtask

  task automatic issue(input entry_t e);
    logic rd_left;
    logic aw_left;
    logic w_left;
    logic rd_take;
    logic aw_take;
    logic w_take;
    rd_left   = (e.op == OP_RD || e.op == OP_RD_Q || e.op == OP_RW);
    aw_left   = (e.op == OP_WR || e.op == OP_WR_Q || e.op == OP_RW);
    w_left    = aw_left;
    arid_i    = e.id;
    araddr_i  = e.addr;
    awid_i    = e.id;
    awaddr_i  = e.addr;
    wdata_i   = e.wdata;
    arvalid_i = rd_left;
    awvalid_i = aw_left;
    wvalid_i  = w_left;
    while (rd_left || aw_left || w_left)
    begin
      rd_take = rd_left && arready_o;   // Handshake on the coming rising edge
      aw_take = aw_left && awready_o;
      w_take  = w_left && wready_o;
      @(negedge ACLK);
      rd_left   = rd_left && !rd_take;
      aw_left   = aw_left && !aw_take;
      w_left    = w_left && !w_take;
      arvalid_i = rd_left;
      awvalid_i = aw_left;
      wvalid_i  = w_left;
    end
  endtask

  task automatic drain();
    while (exp_r.size() != 0 || exp_b.size() != 0)
      @(negedge ACLK);
  endtask

  task automatic finish_response(input int idx, input int errs_before);
    if (n_errs != errs_before)
      bad[idx] = 1'b1;
    pend[idx]--;
    if (pend[idx] == 0)
    begin
      n_done++;
      if (bad[idx])
        n_failed++;
      $display("test %0d id %h addr %h: %s", idx, tab[idx].id, tab[idx].addr,
               bad[idx] ? "failed" : "ok");
    end
  endtask

  // ------------------------------------------------------------
  // Response collectors
  // ------------------------------------------------------------
  initial
  begin
    expect_t x;
    int      errs;
    rready_i = 1'b0;
    forever
    begin
      while (exp_r.size() == 0 || !rvalid_o)
        @(negedge ACLK);
      x = exp_r[0];
      repeat (x.hold) @(negedge ACLK);
      rready_i = 1'b1;
      errs = n_errs;
      check_id("rid_o", x.id, rid_o);
      check_data("rdata_o", x.data, rdata_o);
      check_resp("rresp_o", x.resp, rresp_o);
      @(negedge ACLK);   // Taken on the edge in between
      rready_i = 1'b0;
      void'(exp_r.pop_front());
      finish_response(x.idx, errs);
    end
  end

  initial
  begin
    expect_t x;
    int      errs;
    bready_i = 1'b0;
    forever
    begin
      while (exp_b.size() == 0 || !bvalid_o)
        @(negedge ACLK);
      x = exp_b[0];
      repeat (x.hold) @(negedge ACLK);
      bready_i = 1'b1;
      errs = n_errs;
      check_id("bid_o", x.id, bid_o);
      check_resp("bresp_o", x.resp, bresp_o);
      @(negedge ACLK);
      bready_i = 1'b0;
      void'(exp_b.pop_front());
      finish_response(x.idx, errs);
    end
  end

  initial
  begin
    @(posedge ARESETn);
    #(tab.size() * 60 * CLK_T);
    $display("Timeout: responses still missing after %0d cycles", tab.size() * 60);
    $display(">>> FAIL");
    $finish;
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial
  begin
    logic queued;
    ARESETn   = 1'b0;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    arvalid_i = 1'b0;
    awid_i    = '0;
    awaddr_i  = '0;
    wdata_i   = '0;
    arid_i    = '0;
    araddr_i  = '0;
    n_checks  = 0;
    n_errs    = 0;
    n_done    = 0;
    n_failed  = 0;
    for (int i = 0; i < 16; i++)
      ref_mem[i] = '0;
    void'($urandom(SEED));
    add_entry(OP_WR,   16'h0011, 32'h0000_0000, 32'hCAFE_0000);  // No wait states
    add_entry(OP_RD,   16'h0012, 32'h0000_0000, 32'h0);
    add_entry(OP_WR,   16'h0021, 32'h0000_0004, 32'h1234_5678);
    add_entry(OP_RD,   16'h0022, 32'h0000_0004, 32'h0);
    add_entry(OP_WR,   16'h0031, 32'h0000_0008, 32'h0BAD_F00D);
    add_entry(OP_RD,   16'h0032, 32'h0000_0008, 32'h0);
    add_entry(OP_WR,   16'h0041, 32'h0000_000C, 32'h5555_AAAA);  // Three wait states
    add_entry(OP_RD,   16'h0042, 32'h0000_000C, 32'h0);
    add_entry(OP_WR,   16'h0051, 32'h0000_1004, 32'hDEAD_BEEF);  // Error region
    add_entry(OP_RD,   16'h0052, 32'h0000_1004, 32'h0);
    add_entry(OP_RD,   16'h0053, 32'h0000_0004, 32'h0);
    add_entry(OP_WR,   16'h0054, 32'h0000_100C, 32'hFFFF_FFFF);
    add_entry(OP_RD,   16'h0055, 32'h0000_000C, 32'h0);
    add_entry(OP_RW,   16'h0061, 32'h0000_0010, 32'h0000_7777);
    add_entry(OP_RD,   16'h0062, 32'h0000_0010, 32'h0);
    add_entry(OP_WR_Q, 16'h0071, 32'h0000_0020, 32'h7100_0001);  // Queued batch
    add_entry(OP_WR_Q, 16'h0072, 32'h0000_0024, 32'h7200_0002);
    add_entry(OP_RD_Q, 16'h0073, 32'h0000_0000, 32'h0);
    add_entry(OP_WR_Q, 16'h0074, 32'h0000_0028, 32'h7400_0004);
    add_entry(OP_RD_Q, 16'h0075, 32'h0000_1008, 32'h0);
    add_entry(OP_RD_Q, 16'h0076, 32'h0000_0008, 32'h0);
    add_entry(OP_WR_Q, 16'h0077, 32'h0000_002C, 32'h7700_0007);
    add_entry(OP_RD_Q, 16'h0078, 32'h0000_000C, 32'h0);
    add_entry(OP_WR_Q, 16'h0079, 32'h0000_1030, 32'h7900_0009);
    add_entry(OP_RD,   16'h007A, 32'h0000_0020, 32'h0);
    add_entry(OP_RD,   16'h007B, 32'h0000_002C, 32'h0);
    repeat (2) @(negedge ACLK);
    ARESETn = 1'b1;
    @(negedge ACLK);
    check_flag("rvalid_o", 1'b0, rvalid_o);
    check_flag("bvalid_o", 1'b0, bvalid_o);
    check_flag("penable_o", 1'b0, penable_o);
    check_flag("arready_o", 1'b1, arready_o);
    check_flag("awready_o", 1'b1, awready_o);
    check_flag("wready_o", 1'b1, wready_o);
    for (int i = 0; i < tab.size(); i++)
    begin
      queued = (tab[i].op == OP_WR_Q || tab[i].op == OP_RD_Q);
      if (!queued)
        drain();
      expect_entry(i, tab[i]);
      issue(tab[i]);
      if (tab[i].op == OP_RW)
      begin
        check_flag("penable_o", 1'b1, penable_o);  // First access of the pair
        check_flag("pwrite_o", 1'b0, pwrite_o);
        check_addr("paddr_o", tab[i].addr, paddr_o);
      end
      if (!queued)
        drain();
    end
    drain();
    check_flag("rvalid_o", 1'b0, rvalid_o);  // Nothing left over
    check_flag("bvalid_o", 1'b0, bvalid_o);
    $display("tests %0d of %0d done, %0d failed, %0d checks, %0d errors",
             n_done, tab.size(), n_failed, n_checks, n_errs);
    if (n_errs == 0 && n_done == tab.size())
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: sim/apb_mem_model.sv
/* APB slave model: 16-word memory, address-driven wait states, error region */

`timescale 1ns/1ps

`include "axi2apb_defs.svh"

module apb_mem_model (
  input  logic                       ACLK,
  input  logic                       ARESETn,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [`AXI2APB_ADDR_W-1:0] paddr_i,
  input  logic [`AXI2APB_DATA_W-1:0] pwdata_i,
  output logic [`AXI2APB_DATA_W-1:0] prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o
);

  logic [`AXI2APB_DATA_W-1:0] mem [16];
  logic [15:0]                written;   // Words that hold data since reset
  logic [1:0]                 wait_cnt;
  logic [3:0]                 word;
  logic                       err_addr;

  assign word      = paddr_i[5:2];
  assign err_addr  = paddr_i[12];         // Error region
  assign pready_o  = penable_i && (wait_cnt == paddr_i[3:2]);
  assign pslverr_o = pready_o && err_addr;
  assign prdata_o  = (err_addr || !written[word]) ? '0 : mem[word];

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      wait_cnt <= '0;
      written  <= '0;
    end
    else if (pready_o)
    begin
      wait_cnt <= '0;
      if (pwrite_i && !err_addr)
      begin
        mem[word]     <= pwdata_i;
        written[word] <= 1'b1;
      end
    end
    else if (penable_i)
      wait_cnt <= wait_cnt + 2'd1;  // Stretch the access
  end

endmodule

// File: logic/axi2apb_bridge.sv
/* AXI4 to APB bridge top: five channel FIFOs around the transfer FSM */

`timescale 1ns/1ps

`include "axi2apb_defs.svh"

module axi2apb_bridge (
  input  logic                       ACLK,
  input  logic                       ARESETn,
  // AXI write address
  input  logic [`AXI2APB_ID_W-1:0]   awid_i,
  input  logic [`AXI2APB_ADDR_W-1:0] awaddr_i,
  input  logic                       awvalid_i,
  output logic                       awready_o,
  // AXI write data
  input  logic [`AXI2APB_DATA_W-1:0] wdata_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  // AXI write response
  output logic [`AXI2APB_ID_W-1:0]   bid_o,
  output axi2apb_pkg::axi_resp_e     bresp_o,
  output logic                       bvalid_o,
  input  logic                       bready_i,
  // AXI read address
  input  logic [`AXI2APB_ID_W-1:0]   arid_i,
  input  logic [`AXI2APB_ADDR_W-1:0] araddr_i,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  // AXI read data
  output logic [`AXI2APB_ID_W-1:0]   rid_o,
  output logic [`AXI2APB_DATA_W-1:0] rdata_o,
  output axi2apb_pkg::axi_resp_e     rresp_o,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  // APB master
  output logic                       penable_o,
  output logic                       pwrite_o,
  output logic [`AXI2APB_ADDR_W-1:0] paddr_o,
  output logic [`AXI2APB_DATA_W-1:0] pwdata_o,
  input  logic [`AXI2APB_DATA_W-1:0] prdata_i,
  input  logic                       pready_i,
  input  logic                       pslverr_i
);

  import axi2apb_pkg::*;

  localparam int A_W = `AXI2APB_ID_W + `AXI2APB_ADDR_W;      // {id, addr}
  localparam int R_W = `AXI2APB_ID_W + `AXI2APB_DATA_W + 2;  // {id, data, resp}
  localparam int B_W = `AXI2APB_ID_W + 2;                    // {id, resp}

  // ------------------------------------------------------------
  // FIFO to FSM wiring
  // ------------------------------------------------------------
  logic [A_W-1:0]             aw_word;
  logic [A_W-1:0]             ar_word;
  logic [`AXI2APB_DATA_W-1:0] w_head;
  logic                       aw_head_valid;
  logic                       w_head_valid;
  logic                       ar_head_valid;
  logic                       ar_pop;
  logic                       wr_pop;
  logic                       r_valid;
  logic                       r_ready;
  logic [`AXI2APB_ID_W-1:0]   r_id;
  logic [`AXI2APB_DATA_W-1:0] r_data;
  axi_resp_e                  r_resp;
  logic                       b_valid;
  logic                       b_ready;
  logic [`AXI2APB_ID_W-1:0]   b_id;
  axi_resp_e                  b_resp;
  logic [R_W-1:0]             r_word;
  logic [B_W-1:0]             b_word;
  logic [1:0]                 rresp_bits;
  logic [1:0]                 bresp_bits;

  // Response unpacking back into the enum ports
  assign {rid_o, rdata_o, rresp_bits} = r_word;
  assign {bid_o, bresp_bits}          = b_word;
  assign rresp_o = axi_resp_e'(rresp_bits);
  assign bresp_o = axi_resp_e'(bresp_bits);

  axi_chan_fifo #(.WIDTH(A_W)) aw_fifo (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .in_valid_i(awvalid_i), .in_data_i({awid_i, awaddr_i}), .in_ready_o(awready_o),
    .out_valid_o(aw_head_valid), .out_data_o(aw_word), .out_ready_i(wr_pop)
  );

  axi_chan_fifo #(.WIDTH(`AXI2APB_DATA_W)) w_fifo (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .in_valid_i(wvalid_i), .in_data_i(wdata_i), .in_ready_o(wready_o),
    .out_valid_o(w_head_valid), .out_data_o(w_head), .out_ready_i(wr_pop)
  );

  axi_chan_fifo #(.WIDTH(A_W)) ar_fifo (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .in_valid_i(arvalid_i), .in_data_i({arid_i, araddr_i}), .in_ready_o(arready_o),
    .out_valid_o(ar_head_valid), .out_data_o(ar_word), .out_ready_i(ar_pop)
  );

  axi_chan_fifo #(.WIDTH(R_W)) r_fifo (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .in_valid_i(r_valid), .in_data_i({r_id, r_data, r_resp}), .in_ready_o(r_ready),
    .out_valid_o(rvalid_o), .out_data_o(r_word), .out_ready_i(rready_i)
  );

  axi_chan_fifo #(.WIDTH(B_W)) b_fifo (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .in_valid_i(b_valid), .in_data_i({b_id, b_resp}), .in_ready_o(b_ready),
    .out_valid_o(bvalid_o), .out_data_o(b_word), .out_ready_i(bready_i)
  );

  apb_xfer_fsm fsm0 (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .ar_valid_i(ar_head_valid),
    .ar_id_i(ar_word[A_W-1 -: `AXI2APB_ID_W]),
    .ar_addr_i(ar_word[`AXI2APB_ADDR_W-1:0]),
    .ar_pop_o(ar_pop),
    .aw_valid_i(aw_head_valid),
    .aw_id_i(aw_word[A_W-1 -: `AXI2APB_ID_W]),
    .aw_addr_i(aw_word[`AXI2APB_ADDR_W-1:0]),
    .w_valid_i(w_head_valid), .w_data_i(w_head), .wr_pop_o(wr_pop),
    .r_valid_o(r_valid), .r_ready_i(r_ready),
    .r_id_o(r_id), .r_data_o(r_data), .r_resp_o(r_resp),
    .b_valid_o(b_valid), .b_ready_i(b_ready),
    .b_id_o(b_id), .b_resp_o(b_resp),
    .penable_o(penable_o), .pwrite_o(pwrite_o),
    .paddr_o(paddr_o), .pwdata_o(pwdata_o),
    .prdata_i(prdata_i), .pready_i(pready_i), .pslverr_i(pslverr_i)
  );

endmodule

// File: logic/apb_xfer_fsm.sv
/* Transfer FSM: one APB access per buffered AXI request,
   then a read or write response back to the output FIFOs */

`timescale 1ns/1ps

`include "axi2apb_defs.svh"

module apb_xfer_fsm (
  input  logic                       ACLK,
  input  logic                       ARESETn,
  // Read address FIFO head
  input  logic                       ar_valid_i,
  input  logic [`AXI2APB_ID_W-1:0]   ar_id_i,
  input  logic [`AXI2APB_ADDR_W-1:0] ar_addr_i,
  output logic                       ar_pop_o,
  // Write address and data FIFO heads
  input  logic                       aw_valid_i,
  input  logic [`AXI2APB_ID_W-1:0]   aw_id_i,
  input  logic [`AXI2APB_ADDR_W-1:0] aw_addr_i,
  input  logic                       w_valid_i,
  input  logic [`AXI2APB_DATA_W-1:0] w_data_i,
  output logic                       wr_pop_o,
  // Read response toward the R FIFO
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  output logic [`AXI2APB_ID_W-1:0]   r_id_o,
  output logic [`AXI2APB_DATA_W-1:0] r_data_o,
  output axi2apb_pkg::axi_resp_e     r_resp_o,
  // Write response toward the B FIFO
  output logic                       b_valid_o,
  input  logic                       b_ready_i,
  output logic [`AXI2APB_ID_W-1:0]   b_id_o,
  output axi2apb_pkg::axi_resp_e     b_resp_o,
  // APB master
  output logic                       penable_o,
  output logic                       pwrite_o,
  output logic [`AXI2APB_ADDR_W-1:0] paddr_o,
  output logic [`AXI2APB_DATA_W-1:0] pwdata_o,
  input  logic [`AXI2APB_DATA_W-1:0] prdata_i,
  input  logic                       pready_i,
  input  logic                       pslverr_i
);

  import axi2apb_pkg::*;

  bridge_state_e               state;
  bridge_state_e               state_nxt;
  logic                        rd_go;    // Read access on APB this cycle
  logic                        wr_go;    // Write access on APB this cycle
  logic [`AXI2APB_DATA_W-1:0]  rdata_q;
  logic                        err_q;

  // ------------------------------------------------------------
  // APB access, reads win over writes in IDLE
  // ------------------------------------------------------------
  assign rd_go = (state == IDLE && ar_valid_i) || state == WAIT_R_PREADY;
  assign wr_go = (state == IDLE && !ar_valid_i && aw_valid_i && w_valid_i)
                 || state == WAIT_W_PREADY;

  assign penable_o = rd_go | wr_go;  // No separate setup phase
  assign pwrite_o  = wr_go;
  assign paddr_o   = wr_go ? aw_addr_i : ar_addr_i;
  assign pwdata_o  = w_data_i;

  // ------------------------------------------------------------
  // Responses, IDs come from the heads that are still held
  // ------------------------------------------------------------
  assign r_valid_o = (state == SEND_R_RESP);
  assign r_id_o    = ar_id_i;
  assign r_data_o  = rdata_q;
  assign r_resp_o  = err_q ? RESP_SLVERR : RESP_OKAY;

  assign b_valid_o = (state == SEND_B_RESP);
  assign b_id_o    = aw_id_i;
  assign b_resp_o  = err_q ? RESP_SLVERR : RESP_OKAY;

  // Heads are freed only once the response is taken
  assign ar_pop_o = r_valid_o & r_ready_i;
  assign wr_pop_o = b_valid_o & b_ready_i;

  always_comb
  begin
    state_nxt = state;
    unique case (state)
      IDLE:
      begin
        if (rd_go)
          state_nxt = pready_i ? SEND_R_RESP : WAIT_R_PREADY;
        else if (wr_go)
          state_nxt = pready_i ? SEND_B_RESP : WAIT_W_PREADY;
      end
      WAIT_R_PREADY:
      begin
        if (pready_i)
          state_nxt = SEND_R_RESP;
      end
      WAIT_W_PREADY:
      begin
        if (pready_i)
          state_nxt = SEND_B_RESP;
      end
      SEND_R_RESP:
      begin
        if (r_ready_i)
          state_nxt = IDLE;
      end
      SEND_B_RESP:
      begin
        if (b_ready_i)
          state_nxt = IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  // Completion capture on the pready edge
  always_ff @(posedge ACLK)
  begin
    if (penable_o && pready_i)
    begin
      err_q <= pslverr_i;
      if (!pwrite_o)
        rdata_q <= prdata_i;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  // A stretched access keeps its direction and address
  a_apb_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    penable_o && !pready_i |=> penable_o && $stable(pwrite_o) && $stable(paddr_o));

  // A pop only ever frees heads that are still present
  a_pop_has_head: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (!ar_pop_o || ar_valid_i) && (!wr_pop_o || (aw_valid_i && w_valid_i)));

endmodule

// File: logic/axi_chan_fifo.sv
/* Valid/ready FIFO with configurable word width, one per AXI channel */

`timescale 1ns/1ps

`include "axi2apb_defs.svh"

module axi_chan_fifo #(
  parameter int WIDTH = 32
) (
  input  logic             ACLK,
  input  logic             ARESETn,
  input  logic             in_valid_i,
  input  logic [WIDTH-1:0] in_data_i,
  output logic             in_ready_o,
  output logic             out_valid_o,
  output logic [WIDTH-1:0] out_data_o,
  input  logic             out_ready_i
);

  localparam int DEPTH = `AXI2APB_BUF_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // Occupied entries
  logic             push;
  logic             pop;

  // Wrap at DEPTH so non power of two depths work too
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1))
    begin
      return '0;
    end
    return p + PTR_W'(1);
  endfunction

  assign in_ready_o  = (count != CNT_W'(DEPTH));  // Full drops ready
  assign out_valid_o = (count != '0);
  assign out_data_o  = mem[rd_ptr];               // Head of queue
  assign push        = in_valid_i & in_ready_o;
  assign pop         = out_valid_o & out_ready_i;

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;  // Idle, or push and pop together
      endcase
    end
  end

  always_ff @(posedge ACLK)
  begin
    if (push)
      mem[wr_ptr] <= in_data_i;
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  // Occupancy stays within depth and matches the pointer distance
  a_count_bound: assert property (@(posedge ACLK) disable iff (!ARESETn)
    count <= CNT_W'(DEPTH) && wr_ptr == PTR_W'((int'(rd_ptr) + int'(count)) % DEPTH));

  // Head must hold while the consumer stalls
  a_head_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

// File: logic/axi2apb_pkg.sv
/* Bridge state and AXI response types */

package axi2apb_pkg;

  // ------------------------------------------------------------
  // Transfer FSM states
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    IDLE,           // Waiting for a request at a FIFO head
    WAIT_R_PREADY,  // Read access stretched by the APB slave
    WAIT_W_PREADY,  // Write access stretched by the APB slave
    SEND_R_RESP,    // Offering read data to the R FIFO
    SEND_B_RESP     // Offering write response to the B FIFO
  } bridge_state_e;

  // ------------------------------------------------------------
  // AXI response codes, only the ones the bridge can return
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10  // APB slave flagged PSLVERR
  } axi_resp_e;

endpackage

// File: include/axi2apb_defs.svh
/* Width and depth macros for the AXI4-to-APB bridge */

`ifndef AXI2APB_DEFS_SVH
`define AXI2APB_DEFS_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------
`define AXI2APB_ADDR_W 32   // AXI and APB address
`define AXI2APB_DATA_W 32   // Read and write data
`define AXI2APB_ID_W 16     // AXI transaction ID

// ------------------------------------------------------------
// Channel buffering
// ------------------------------------------------------------

// Entries in every AXI channel FIFO
`define AXI2APB_BUF_DEPTH 4

`endif
